// File: ar_window.sv
`timescale 1ns/1ps

module ar_window import sys_pkg::*; (
	input  logic        clk_sys,
	input  logic        resetd,
	input  ar_t         i_arx,
	input  ar_t         i_ary,
	video_cfg_if.calc   cfg,
	muldiv_if.master    md,
	output coord_t      o_hmin,
	output coord_t      o_hmax,
	output coord_t      o_vmin,
	output coord_t      o_vmax
);

	ar_state_t state;
	ar_t       sel_x, sel_y;
	coord_t    th, tw;
	coord_t    rx, ry;
	logic      rabs;
	logic      direct;
	coord_t    w, h;
	coord_t    vw, vh;
	coord_t    hoff, voff;

	// ary of 0 picks a custom ratio by index in arx
	always_comb begin
		sel_x = i_arx;
		sel_y = i_ary;
		if (i_ary == '0) begin
			case (i_arx)
				13'd1: begin
					sel_x = cfg.arc1x;
					sel_y = cfg.arc1y;
				end
				13'd2: begin
					sel_x = cfg.arc2x;
					sel_y = cfg.arc2y;
				end
				default: begin
					sel_x = '0;
					sel_y = '0;
				end
			endcase
		end
	end

	// fill the whole target, no ratio to keep
	assign direct = cfg.freescale || (rx == '0) || (ry == '0);

	assign hoff = (cfg.width - vw) >> 1;
	assign voff = (cfg.height - vh) >> 1;

	//////////////////////////////
	// datapath
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		th   <= (cfg.vset != '0 && cfg.vset < cfg.height) ? cfg.vset : cfg.height;
		tw   <= (cfg.hset != '0 && cfg.hset < cfg.width) ? cfg.hset : cfg.width;
		rx   <= sel_x[11:0];
		ry   <= sel_y[11:0];
		rabs <= sel_x[12] | sel_y[12];
		case (state)
			IDLE: begin
				if (direct) begin
					w <= tw;
					h <= th;
				end else if (rabs) begin
					w <= rx;
					h <= ry;
				end
			end
			MUL_W: begin
				md.mul1 <= th;
				md.mul2 <= rx;
				md.div  <= ry;
			end
			WAIT_W: w <= md.result;
			MUL_H: begin
				md.mul1 <= tw;
				md.mul2 <= ry;
				md.div  <= rx;
			end
			WAIT_H: h <= md.result;
			CLAMP: begin
				vw <= (w > tw) ? tw : w;
				vh <= (h > th) ? th : h;
			end
			default: ;
		endcase
	end

	//////////////////////////////
	// pass sequencing
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state    <= IDLE;
			md.start <= 1'b0;
			o_hmin   <= '0;
			o_hmax   <= '0;
			o_vmin   <= '0;
			o_vmax   <= '0;
		end else begin
			md.start <= 1'b0;
			case (state)
				IDLE: state <= (direct || rabs) ? CLAMP : MUL_W;
				MUL_W: begin
					md.start <= 1'b1;
					state    <= WAIT_W;
				end
				// start still high on the first wait cycle
				WAIT_W: if (!md.start && !md.busy) state <= MUL_H;
				MUL_H: begin
					md.start <= 1'b1;
					state    <= WAIT_H;
				end
				WAIT_H: if (!md.start && !md.busy) state <= CLAMP;
				CLAMP: state <= CENTER;
				CENTER: begin
					o_hmin <= hoff;
					o_hmax <= hoff + vw - 12'd1;
					o_vmin <= voff;
					o_vmax <= voff + vh - 12'd1;
					state  <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// File: cfg_regs.sv
`timescale 1ns/1ps

module cfg_regs import sys_pkg::*; #(
	parameter coord_t DEF_W = DEF_WIDTH,
	parameter coord_t DEF_H = DEF_HEIGHT
) (
	input  logic          clk_sys,
	input  logic          resetd,
	input  logic          i_frame,
	input  logic          i_word_stb,
	input  io_word_t      i_word,
	input  logic [7:0]    i_led_status,
	output logic [7:0]    o_led,
	video_cfg_if.cfg      cfg
);

	logic       has_cmd;
	cmd_t       cmd;
	logic [7:0] cnt;
	logic [7:0] led_overtake;
	logic [7:0] led_state;

	//////////////////////////////
	// command decode
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd       <= 1'b0;
			cmd           <= '0;
			cnt           <= '0;
			cfg.width     <= DEF_W;
			cfg.height    <= DEF_H;
			cfg.vset      <= '0;
			cfg.hset      <= '0;
			cfg.freescale <= 1'b0;
			cfg.arc1x     <= '0;
			cfg.arc1y     <= '0;
			cfg.arc2x     <= '0;
			cfg.arc2y     <= '0;
			led_overtake  <= '0;
			led_state     <= '0;
		end else if (!i_frame) begin
			// frame closed, next word is a command again
			has_cmd <= 1'b0;
			cmd     <= '0;
		end else if (i_word_stb) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= i_word[7:0];
				cnt     <= '0;
			end else begin
				cnt <= cnt + 8'd1;
				case (cmd)
					CMD_VIDEO: begin
						// only width and height matter here, timings are skipped
						if (cnt == 8'd0) begin
							cfg.width <= i_word[11:0];
						end
						if (cnt == 8'd4) begin
							cfg.height <= i_word[11:0];
						end
					end
					CMD_LED: begin
						led_overtake <= i_word[15:8];
						led_state    <= i_word[7:0];
					end
					CMD_VSET: begin
						cfg.vset <= i_word[11:0];
					end
					CMD_HSET: begin
						cfg.freescale <= i_word[15];
						cfg.hset      <= i_word[11:0];
					end
					CMD_ARC: begin
						case (cnt)
							8'd0: cfg.arc1x <= i_word[12:0];
							8'd1: cfg.arc1y <= i_word[12:0];
							8'd2: cfg.arc2x <= i_word[12:0];
							8'd3: cfg.arc2y <= i_word[12:0];
							default: ;
						endcase
					end
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////
	// main board leds
	//////////////////////////////

	// host owns the masked bits, core status shows through the rest
	assign o_led = (led_overtake & led_state) | (~led_overtake & i_led_status);

endmodule

// File: filelist.f
sys_pkg.sv
sys_ifs.sv
host_link.sv
cfg_regs.sv
umuldiv.sv
ar_window.sv
sys_top.sv
tb_sys_top.sv

// File: host_link.sv
`timescale 1ns/1ps

module host_link import sys_pkg::*; (
	input  logic     clk_sys,
	input  logic     resetd,
	input  logic     i_req,
	input  io_word_t i_din,
	output logic     o_ack,
	output logic     o_word_stb,
	output io_word_t o_word
);

	logic req_q;
	logic take;

	// new request seen while the previous one is fully closed
	assign take = req_q & ~o_ack;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			req_q      <= 1'b0;
			o_ack      <= 1'b0;
			o_word_stb <= 1'b0;
		end else begin
			req_q      <= i_req;
			o_word_stb <= 1'b0;
			if (take) begin
				o_ack      <= 1'b1;
				o_word_stb <= 1'b1;
			end else if (!req_q && o_ack) begin
				// host has let go, close the handshake
				o_ack <= 1'b0;
			end
		end
	end

	// data is stable while req is high
	always_ff @(posedge clk_sys) begin
		if (take) begin
			o_word <= i_din;
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_sys_top \
	-Mdir obj_dir -o tb_sys_top
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_sys_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
	exit 1
fi
exit 0

// File: sys_ifs.sv
`timescale 1ns/1ps

// video configuration from the register block to the window calculator
interface video_cfg_if import sys_pkg::*; ();

	coord_t width;
	coord_t height;
	coord_t vset;
	coord_t hset;
	logic   freescale;
	ar_t    arc1x;
	ar_t    arc1y;
	ar_t    arc2x;
	ar_t    arc2y;

	modport cfg (
		output width, height, vset, hset, freescale,
		output arc1x, arc1y, arc2x, arc2y
	);

	modport calc (
		input width, height, vset, hset, freescale,
		input arc1x, arc1y, arc2x, arc2y
	);

endinterface

// request and result of the serial multiply-divide
interface muldiv_if import sys_pkg::*; ();

	logic   start;
	coord_t mul1;
	coord_t mul2;
	coord_t div;
	logic   busy;
	coord_t result;

	modport master (output start, mul1, mul2, div, input busy, result);
	modport slave (input start, mul1, mul2, div, output busy, result);

endinterface

// File: sys_pkg.sv
package sys_pkg;

	//////////////////////////////
	// widths with a meaning
	//////////////////////////////

	// screen coordinate or size in pixels or lines
	typedef logic [11:0] coord_t;

	// aspect component, bit 12 flags an absolute size
	typedef logic [12:0] ar_t;

	// host data word
	typedef logic [15:0] io_word_t;

	// host command code
	typedef logic [7:0] cmd_t;

	//////////////////////////////
	// host command codes
	//////////////////////////////

	localparam cmd_t CMD_VIDEO = 8'h20;
	localparam cmd_t CMD_LED   = 8'h25;
	localparam cmd_t CMD_VSET  = 8'h27;
	localparam cmd_t CMD_HSET  = 8'h37;
	localparam cmd_t CMD_ARC   = 8'h3A;

	// video size after reset
	localparam coord_t DEF_WIDTH  = 12'd1920;
	localparam coord_t DEF_HEIGHT = 12'd1080;

	// cycles of one window pass, divider time not included
	localparam int AR_PASS_MAX = 64;

	// window calculator states
	typedef enum logic [2:0] {
		IDLE, MUL_W, WAIT_W, MUL_H, WAIT_H, CLAMP, CENTER
	} ar_state_t;

endpackage

// File: sys_top.sv
`timescale 1ns/1ps

module sys_top import sys_pkg::*; #(
	parameter coord_t DEF_W = DEF_WIDTH,
	parameter coord_t DEF_H = DEF_HEIGHT
) (
	input  logic       clk_sys,
	input  logic       resetd,
	input  logic       i_io_req,
	input  logic       i_io_frame,
	input  io_word_t   i_io_din,
	output logic       o_io_ack,
	input  ar_t        i_arx,
	input  ar_t        i_ary,
	input  logic [7:0] i_led_status,
	output logic [7:0] o_led,
	output coord_t     o_hmin,
	output coord_t     o_hmax,
	output coord_t     o_vmin,
	output coord_t     o_vmax
);

	logic     word_stb;
	io_word_t word;

	video_cfg_if u_vcfg ();
	muldiv_if    u_md ();

	//////////////////////////////
	// host side
	//////////////////////////////

	host_link u_link (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_req      (i_io_req),
		.i_din      (i_io_din),
		.o_ack      (o_io_ack),
		.o_word_stb (word_stb),
		.o_word     (word)
	);

	cfg_regs #(
		.DEF_W (DEF_W),
		.DEF_H (DEF_H)
	) u_regs (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_frame      (i_io_frame),
		.i_word_stb   (word_stb),
		.i_word       (word),
		.i_led_status (i_led_status),
		.o_led        (o_led),
		.cfg          (u_vcfg.cfg)
	);

	//////////////////////////////
	// window calculation
	//////////////////////////////

	ar_window u_win (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_arx   (i_arx),
		.i_ary   (i_ary),
		.cfg     (u_vcfg.calc),
		.md      (u_md.master),
		.o_hmin  (o_hmin),
		.o_hmax  (o_hmax),
		.o_vmin  (o_vmin),
		.o_vmax  (o_vmax)
	);

	umuldiv #(
		.W ($bits(coord_t))
	) u_muldiv (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.md      (u_md.slave)
	);

endmodule

// File: tb_sys_top.sv
`timescale 1ns/1ps

module tb_sys_top import sys_pkg::*;;

	localparam int SETTLE          = 200;
	localparam int ACK_WAIT        = 20;
	localparam int TEST_COUNT      = 6;
	localparam int CYCLES_PER_TEST = 1000;
	localparam int CYCLE_LIMIT     = TEST_COUNT * CYCLES_PER_TEST;

	logic       clk_sys = 1'b0;
	logic       resetd;
	logic       i_io_req;
	logic       i_io_frame;
	io_word_t   i_io_din;
	logic       o_io_ack;
	ar_t        i_arx;
	ar_t        i_ary;
	logic [7:0] i_led_status;
	logic [7:0] o_led;
	coord_t     o_hmin, o_hmax, o_vmin, o_vmax;

	int          mismatches = 0;
	int          other_errors = 0;
	int          cycles = 0;
	logic [15:0] lfsr = 16'd65366;

	// expected configuration as the host has written it
	int  m_width = 1920;
	int  m_height = 1080;
	int  m_vset = 0;
	int  m_hset = 0;
	bit  m_fs = 1'b0;
	ar_t m_arc[4] = '{default: '0};

	sys_top u_dut (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_io_req     (i_io_req),
		.i_io_frame   (i_io_frame),
		.i_io_din     (i_io_din),
		.o_io_ack     (o_io_ack),
		.i_arx        (i_arx),
		.i_ary        (i_ary),
		.i_led_status (i_led_status),
		.o_led        (o_led),
		.o_hmin       (o_hmin),
		.o_hmax       (o_hmax),
		.o_vmin       (o_vmin),
		.o_vmax       (o_vmax)
	);

	always #50 clk_sys = ~clk_sys;

	// watchdog
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			other_errors = other_errors + 1;
			$display("run stopped at the cycle limit of %0d", CYCLE_LIMIT);
			$display("errors: %0d mismatches, %0d other", mismatches, other_errors);
			$display("*** FAILED ***");
			$finish;
		end
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	// taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			b    = {b[6:0], lfsr[15]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic tick(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			mismatches = mismatches + 1;
			$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic write_word(input io_word_t w);
		int n;
		i_io_din = w;
		i_io_req = 1'b1;
		n = 0;
		while (!o_io_ack && n < ACK_WAIT) begin
			tick(1);
			n++;
		end
		if (!o_io_ack) begin
			other_errors = other_errors + 1;
			$display("ack did not rise at %0t", $time);
		end
		i_io_req = 1'b0;
		n = 0;
		while (o_io_ack && n < ACK_WAIT) begin
			tick(1);
			n++;
		end
		if (o_io_ack) begin
			other_errors = other_errors + 1;
			$display("ack did not fall at %0t", $time);
		end
	endtask

	task automatic write_frame(input cmd_t command, input io_word_t words[$]);
		i_io_frame = 1'b1;
		write_word({8'h00, command});
		foreach (words[i]) begin
			write_word(words[i]);
		end
		i_io_frame = 1'b0;
		tick(1);
	endtask

	// centered window from the configuration as packed hmin hmax vmin vmax
	function automatic logic [47:0] window_ref(input ar_t arx, input ar_t ary);
		ar_t ex, ey;
		int  th, tw, rx, ry, w, h, vw, vh, hmin, vmin;
		th = (m_vset != 0 && m_vset < m_height) ? m_vset : m_height;
		tw = (m_hset != 0 && m_hset < m_width) ? m_hset : m_width;
		ex = arx;
		ey = ary;
		if (ary == '0) begin
			ex = (arx == 13'd1) ? m_arc[0] : (arx == 13'd2) ? m_arc[2] : '0;
			ey = (arx == 13'd1) ? m_arc[1] : (arx == 13'd2) ? m_arc[3] : '0;
		end
		rx = int'(ex[11:0]);
		ry = int'(ey[11:0]);
		if (m_fs || rx == 0 || ry == 0) begin
			w = tw;
			h = th;
		end else if (ex[12] || ey[12]) begin
			w = rx;
			h = ry;
		end else begin
			w = (th * rx / ry) % 4096;
			h = (tw * ry / rx) % 4096;
		end
		vw   = (w < tw) ? w : tw;
		vh   = (h < th) ? h : th;
		hmin = (m_width - vw) / 2;
		vmin = (m_height - vh) / 2;
		return {12'(hmin), 12'(hmin + vw - 1), 12'(vmin), 12'(vmin + vh - 1)};
	endfunction

	task automatic check_window(input int hmin, input int hmax, input int vmin, input int vmax);
		check("o_hmin", 32'(o_hmin), hmin);
		check("o_hmax", 32'(o_hmax), hmax);
		check("o_vmin", 32'(o_vmin), vmin);
		check("o_vmax", 32'(o_vmax), vmax);
	endtask

	task automatic check_window_ref(input ar_t arx, input ar_t ary);
		logic [47:0] r;
		r = window_ref(arx, ary);
		check_window(int'(r[47:36]), int'(r[35:24]), int'(r[23:12]), int'(r[11:0]));
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic test_reset_state();
		logic [7:0] st;
		rand_byte(st);
		i_led_status = st;
		tick(1);
		check("o_io_ack", 32'(o_io_ack), 0);
		check("o_led", 32'(o_led), 32'(st));
		tick(SETTLE);
		check_window(0, 1919, 0, 1079);
	endtask

	task automatic test_led_overtake();
		io_word_t   words[$];
		logic [7:0] mask, state, st, exp_led;
		rand_byte(mask);
		rand_byte(state);
		words.push_back({mask, state});
		write_frame(CMD_LED, words);
		repeat (6) begin
			rand_byte(st);
			i_led_status = st;
			// each led is the host state where masked, else the core status
			for (int b = 0; b < 8; b++) begin
				exp_led[b] = mask[b] ? state[b] : st[b];
			end
			tick(1);
			check("o_led", 32'(o_led), 32'(exp_led));
		end
	endtask

	task automatic test_ratio_4_3();
		i_arx = 13'd4;
		i_ary = 13'd3;
		tick(SETTLE);
		check_window(240, 1679, 0, 1079);
	endtask

	task automatic test_mode_720();
		io_word_t words[$];
		words = '{16'd1280, 16'd0, 16'd0, 16'd0, 16'd720, 16'd0, 16'd0, 16'd0};
		write_frame(CMD_VIDEO, words);
		m_width  = 1280;
		m_height = 720;
		words = '{16'd600};
		write_frame(CMD_VSET, words);
		m_vset = 600;
		i_arx  = 13'd16;
		i_ary  = 13'd9;
		tick(SETTLE);
		check_window(107, 1172, 60, 659);
	endtask

	task automatic test_absolute_free();
		io_word_t words[$];
		words = '{16'd0};
		write_frame(CMD_VSET, words);
		m_vset = 0;
		// absolute 800 by 600
		i_arx = 13'h1320;
		i_ary = 13'h1258;
		tick(SETTLE);
		check_window(240, 1039, 60, 659);
		words = '{16'h8000};
		write_frame(CMD_HSET, words);
		m_fs = 1'b1;
		tick(SETTLE);
		check_window(0, 1279, 0, 719);
	endtask

	task automatic test_custom_ratio();
		io_word_t words[$];
		words = '{16'h0000};
		write_frame(CMD_HSET, words);
		m_fs  = 1'b0;
		words = '{16'd16, 16'd9, 16'd5, 16'd4};
		write_frame(CMD_ARC, words);
		m_arc = '{13'd16, 13'd9, 13'd5, 13'd4};
		i_arx = 13'd2;
		i_ary = 13'd0;
		tick(SETTLE);
		check_window_ref(i_arx, i_ary);
		// outside a frame this would set vset 256
		i_io_frame = 1'b0;
		write_word({8'h00, CMD_VSET});
		write_word(16'h0100);
		tick(SETTLE);
		check_window_ref(i_arx, i_ary);
	endtask

	initial begin
		resetd       = 1'b1;
		i_io_req     = 1'b0;
		i_io_frame   = 1'b0;
		i_io_din     = '0;
		i_arx        = '0;
		i_ary        = '0;
		i_led_status = '0;
		repeat (8) @(posedge clk_sys);
		#1;
		resetd = 1'b0;

		test_reset_state();
		test_led_overtake();
		test_ratio_4_3();
		test_mode_720();
		test_absolute_free();
		test_custom_ratio();

		$display("errors: %0d mismatches, %0d other", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: umuldiv.sv
`timescale 1ns/1ps

module umuldiv import sys_pkg::*; #(
	parameter int W = 12
) (
	input  logic     clk_sys,
	input  logic     resetd,
	muldiv_if.slave  md
);

	localparam int CW = $clog2(2 * W);

	typedef enum logic [1:0] {MD_IDLE, MD_MUL, MD_DIV} md_state_t;

	md_state_t      state;
	logic [CW-1:0]  cnt;
	logic [W-1:0]   mcand;
	logic [W-1:0]   dvs;
	// product during multiply and then dividend and quotient
	logic [2*W-1:0] prod;
	logic [W-1:0]   rem;
	logic [W:0]     psum;
	logic [W:0]     rem_sh;

	assign psum   = {1'b0, prod[2*W-1:W]} + {1'b0, mcand};
	assign rem_sh = {rem, prod[2*W-1]};

	assign md.busy   = (state != MD_IDLE);
	// a zero divisor always subtracts so the quotient comes out all ones
	assign md.result = prod[W-1:0];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state <= MD_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				MD_IDLE: if (md.start) begin
					state <= MD_MUL;
					cnt   <= '0;
				end
				MD_MUL: begin
					cnt <= cnt + 1'b1;
					if (cnt == CW'(W - 1)) begin
						state <= MD_DIV;
						cnt   <= '0;
					end
				end
				MD_DIV: begin
					cnt <= cnt + 1'b1;
					if (cnt == CW'(2 * W - 1)) state <= MD_IDLE;
				end
				default: state <= MD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		case (state)
			MD_IDLE: if (md.start) begin
				mcand <= md.mul1;
				dvs   <= md.div;
				prod  <= {{W{1'b0}}, md.mul2};
			end
			MD_MUL: begin
				// shift-add with the multiplier bits leaving at the bottom
				prod <= prod[0] ? {psum, prod[W-1:1]} : {1'b0, prod[2*W-1:1]};
				rem  <= '0;
			end
			MD_DIV: begin
				if (rem_sh >= {1'b0, dvs}) begin
					rem  <= W'(rem_sh - {1'b0, dvs});
					prod <= {prod[2*W-2:0], 1'b1};
				end else begin
					rem  <= rem_sh[W-1:0];
					prod <= {prod[2*W-2:0], 1'b0};
				end
			end
			default: ;
		endcase
	end

endmodule
